/* common/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regNumT;

    localparam wordT resetPc = 32'h0000_3000;  // first fetch address

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a
    } functT;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} aluOpT;
    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_LINK} resultSrcT;
    typedef enum logic [1:0] {MEM_NONE, MEM_WORD, MEM_BYTE_S, MEM_BYTE_U} memOpT;
    typedef logic [1:0] tnewT;  // stages left until the result exists
    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwdSelT;

    typedef struct packed {
        wordT pc;
        wordT instr;
    } fdPayloadT;

    typedef struct packed {
        wordT      pc;
        regNumT    rsNum;
        regNumT    rtNum;
        wordT      rsVal;
        wordT      rtVal;
        wordT      imm;
        regNumT    dest;
        logic      regWrite;
        aluOpT     aluOp;
        resultSrcT resultSrc;
        memOpT     memOp;
        logic      store;
        tnewT      tnew;
    } dePayloadT;

    typedef struct packed {
        wordT      pc;
        wordT      aluResult;
        wordT      storeData;
        regNumT    dest;        // rt of a store, for store-data forwarding
        logic      regWrite;
        resultSrcT resultSrc;
        memOpT     memOp;
        logic      store;
        tnewT      tnew;
    } emPayloadT;

    typedef struct packed {
        wordT   pc;
        wordT   result;
        regNumT dest;
        logic   regWrite;
    } mwPayloadT;

endpackage

/* hdl/pipeReg.sv */
`timescale 1ns/10ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hold,
    input  logic    bubble,
    input  payloadT d,
    output payloadT q
);

    // all-zero payload is a no-op with write and store cleared
    always_ff @(posedge clk) begin
        if (!rstN || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/10ps

module fetchStage #(
    parameter cpuPkg::wordT resetPc = cpuPkg::resetPc
) (
    input  logic         clk,
    input  logic         rstN,
    input  logic         stall,
    input  logic         redirect,
    input  cpuPkg::wordT target,
    output cpuPkg::wordT pc
);
    import cpuPkg::*;

    wordT nextPc;

    // redirect comes from the branch in decode, so the delay slot is already fetched
    assign nextPc = redirect ? target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

endmodule

/* decode/regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           we,
    input  cpuPkg::regNumT wNum,
    input  cpuPkg::regNumT rNum1,
    input  cpuPkg::regNumT rNum2,
    input  cpuPkg::wordT   wData,
    output cpuPkg::wordT   rData1,
    output cpuPkg::wordT   rData2
);
    import cpuPkg::*;

    wordT regs [0:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wNum != 5'd0) begin
            regs[wNum] <= wData;
        end
    end

    // writeback value bypasses the array
    assign rData1 = (rNum1 == 5'd0) ? '0 : (we && wNum == rNum1) ? wData : regs[rNum1];
    assign rData2 = (rNum2 == 5'd0) ? '0 : (we && wNum == rNum2) ? wData : regs[rNum2];

endmodule

/* decode/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::fdPayloadT fd,
    input  cpuPkg::regNumT    wbNum,
    input  logic              wbWrite,
    input  cpuPkg::wordT      wbData,
    input  cpuPkg::wordT      memResult,
    input  cpuPkg::fwdSelT    fwdRs,
    input  cpuPkg::fwdSelT    fwdRt,
    output cpuPkg::regNumT    rsNum,
    output cpuPkg::regNumT    rtNum,
    output logic              useRsD,
    output logic              useRtD,
    output logic              redirect,
    output cpuPkg::wordT      target,
    output cpuPkg::dePayloadT de
);
    import cpuPkg::*;

    opcodeT    opcode;
    functT     funct;
    regNumT    destNum;
    aluOpT     aluOp;
    resultSrcT resultSrc;
    memOpT     memOp;
    tnewT      tnew;
    logic      readsRs, readsRt, immOperand, wantWrite, store;
    logic      isBeq, isBne, isJal, isJr, operandsEqual;
    wordT      rsRaw, rtRaw, rsVal, rtVal, immSext, immZext, pc4;

    assign opcode  = opcodeT'(fd.instr[31:26]);
    assign funct   = functT'(fd.instr[5:0]);
    assign immSext = {{16{fd.instr[15]}}, fd.instr[15:0]};
    assign immZext = {16'h0000, fd.instr[15:0]};
    assign pc4     = fd.pc + 32'd4;

    always_comb begin
        readsRs    = 1'b0;
        readsRt    = 1'b0;
        useRsD     = 1'b0;
        useRtD     = 1'b0;
        immOperand = 1'b0;
        wantWrite  = 1'b0;
        store      = 1'b0;
        isBeq      = 1'b0;
        isBne      = 1'b0;
        isJal      = 1'b0;
        isJr       = 1'b0;
        destNum    = fd.instr[20:16];  // rt unless overridden
        aluOp      = ALU_ADD;
        resultSrc  = RES_ALU;
        memOp      = MEM_NONE;
        tnew       = 2'd0;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == F_JR) begin
                    readsRs = 1'b1;
                    useRsD  = 1'b1;
                    isJr    = 1'b1;
                end else if (funct inside {F_ADDU, F_SUBU, F_AND, F_OR, F_SLT}) begin
                    readsRs   = 1'b1;
                    readsRt   = 1'b1;
                    wantWrite = 1'b1;
                    destNum   = fd.instr[15:11];
                    tnew      = 2'd1;
                    case (funct)
                        F_SUBU:  aluOp = ALU_SUB;
                        F_AND:   aluOp = ALU_AND;
                        F_OR:    aluOp = ALU_OR;
                        F_SLT:   aluOp = ALU_SLT;
                        default: aluOp = ALU_ADD;
                    endcase
                end
            end
            OP_ORI, OP_LUI: begin
                readsRs    = (opcode == OP_ORI);  // lui has no source
                wantWrite  = 1'b1;
                immOperand = 1'b1;
                aluOp      = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                tnew       = 2'd1;
            end
            OP_LW, OP_LB, OP_LBU: begin
                readsRs   = 1'b1;
                wantWrite = 1'b1;
                resultSrc = RES_MEM;
                memOp     = (opcode == OP_LW) ? MEM_WORD :
                            (opcode == OP_LB) ? MEM_BYTE_S : MEM_BYTE_U;
                tnew      = 2'd2;
            end
            OP_SW, OP_SB: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
                store   = 1'b1;
                memOp   = (opcode == OP_SW) ? MEM_WORD : MEM_BYTE_U;
            end
            OP_BEQ, OP_BNE: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
                useRsD  = 1'b1;
                useRtD  = 1'b1;
                isBeq   = (opcode == OP_BEQ);
                isBne   = (opcode == OP_BNE);
            end
            OP_JAL: begin
                wantWrite = 1'b1;
                destNum   = 5'd31;
                resultSrc = RES_LINK;
                isJal     = 1'b1;
                tnew      = 2'd1;
            end
            default: ;  // anything else passes as a no-op
        endcase
    end

    // unused source fields read as r0 so they never stall or forward
    assign rsNum = readsRs ? fd.instr[25:21] : 5'd0;
    assign rtNum = readsRt ? fd.instr[20:16] : 5'd0;

    regFile regFile_i (
        .clk   (clk),
        .rstN  (rstN),
        .we    (wbWrite),
        .wNum  (wbNum),
        .rNum1 (rsNum),
        .rNum2 (rtNum),
        .wData (wbData),
        .rData1(rsRaw),
        .rData2(rtRaw)
    );

    assign rsVal = (fwdRs == FWD_MEM) ? memResult : rsRaw;
    assign rtVal = (fwdRt == FWD_MEM) ? memResult : rtRaw;

    assign operandsEqual = (rsVal == rtVal);
    assign redirect = isJr || isJal || (isBeq && operandsEqual) || (isBne && !operandsEqual);

    always_comb begin
        if (isJr) begin
            target = rsVal;
        end else if (isJal) begin
            target = {pc4[31:28], fd.instr[25:0], 2'b00};
        end else begin
            target = pc4 + {immSext[29:0], 2'b00};
        end
    end

    always_comb begin
        de.pc        = fd.pc;
        de.rsNum     = rsNum;
        de.rtNum     = rtNum;
        de.rsVal     = rsVal;
        de.rtVal     = immOperand ? immZext : rtVal;
        de.imm       = isJal ? fd.pc + 32'd8 : immSext;  // link value rides in imm
        de.dest      = destNum;
        de.regWrite  = wantWrite && destNum != 5'd0;
        de.aluOp     = aluOp;
        de.resultSrc = resultSrc;
        de.memOp     = memOp;
        de.store     = store;
        de.tnew      = tnew;
    end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
    input  cpuPkg::regNumT    rsNum,
    input  cpuPkg::regNumT    rtNum,
    input  logic              useRsD,
    input  logic              useRtD,
    input  cpuPkg::dePayloadT de,
    input  cpuPkg::emPayloadT em,
    input  cpuPkg::regNumT    wbNum,
    input  logic              wbWrite,
    output logic              stall,
    output cpuPkg::fwdSelT    fwdRsD,
    output cpuPkg::fwdSelT    fwdRtD,
    output cpuPkg::fwdSelT    fwdRsE,
    output cpuPkg::fwdSelT    fwdRtE,
    output cpuPkg::fwdSelT    fwdRtM
);
    import cpuPkg::*;

    tnewT tuseRs, tuseRt;

    // producer still owes its result past the point the source is needed
    function automatic logic notReady(regNumT src, tnewT tuse, dePayloadT deP, emPayloadT emP);
        return src != 5'd0 &&
               ((deP.regWrite && deP.dest == src && deP.tnew > tuse) ||
                (emP.regWrite && emP.dest == src && emP.tnew > tuse));
    endfunction

    // youngest ready producer wins
    function automatic fwdSelT forwardFor(regNumT src, emPayloadT emP, regNumT wNum, logic wWrite);
        if (src != 5'd0 && emP.regWrite && emP.dest == src && emP.tnew == 2'd0) begin
            return FWD_MEM;
        end
        if (src != 5'd0 && wWrite && wNum == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign tuseRs = useRsD ? 2'd0 : 2'd1;  // decode use or execute use
    assign tuseRt = useRtD ? 2'd0 : 2'd1;

    assign stall = notReady(rsNum, tuseRs, de, em) || notReady(rtNum, tuseRt, de, em);

    // regfile bypass already covers writeback in decode
    assign fwdRsD = forwardFor(rsNum, em, wbNum, 1'b0);
    assign fwdRtD = forwardFor(rtNum, em, wbNum, 1'b0);
    assign fwdRsE = forwardFor(de.rsNum, em, wbNum, wbWrite);
    assign fwdRtE = forwardFor(de.rtNum, em, wbNum, wbWrite);

    assign fwdRtM = (em.store && wbWrite && em.dest != 5'd0 && wbNum == em.dest) ?
                    FWD_WB : FWD_RF;

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/10ps

module executeStage (
    input  cpuPkg::dePayloadT de,
    input  cpuPkg::wordT      memResult,
    input  cpuPkg::wordT      wbData,
    input  cpuPkg::fwdSelT    fwdRs,
    input  cpuPkg::fwdSelT    fwdRt,
    output cpuPkg::emPayloadT em
);
    import cpuPkg::*;

    wordT rsVal, rtVal, opB, aluOut;

    function automatic wordT pickOperand(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign rsVal = pickOperand(fwdRs, de.rsVal, memResult, wbData);
    assign rtVal = pickOperand(fwdRt, de.rtVal, memResult, wbData);

    // loads and stores add the offset, ori/lui carry their immediate in rtVal
    assign opB = (de.memOp != MEM_NONE) ? de.imm : rtVal;

    always_comb begin
        case (de.aluOp)
            ALU_ADD: aluOut = rsVal + opB;
            ALU_SUB: aluOut = rsVal - opB;
            ALU_AND: aluOut = rsVal & opB;
            ALU_OR:  aluOut = rsVal | opB;
            ALU_SLT: aluOut = {31'd0, $signed(rsVal) < $signed(opB)};
            ALU_LUI: aluOut = {opB[15:0], 16'h0000};
            default: aluOut = '0;
        endcase
    end

    always_comb begin
        em.pc        = de.pc;
        em.aluResult = (de.resultSrc == RES_LINK) ? de.imm : aluOut;
        em.storeData = rtVal;
        em.dest      = de.dest;
        em.regWrite  = de.regWrite;
        em.resultSrc = de.resultSrc;
        em.memOp     = de.memOp;
        em.store     = de.store;
        em.tnew      = (de.tnew == 2'd0) ? 2'd0 : de.tnew - 2'd1;
    end

endmodule

/* hdl/memoryStage.sv */
`timescale 1ns/10ps

module memoryStage (
    input  cpuPkg::emPayloadT em,
    input  cpuPkg::wordT      memReadData,
    input  cpuPkg::wordT      wbData,
    input  cpuPkg::fwdSelT    fwdRt,
    output cpuPkg::wordT      memAddr,
    output cpuPkg::wordT      memWriteData,
    output logic [3:0]        memByteEn,
    output cpuPkg::wordT      memResult,
    output cpuPkg::mwPayloadT mw
);
    import cpuPkg::*;

    wordT       storeData, loadData;
    logic [7:0] loadByte;

    assign storeData = (fwdRt == FWD_WB) ? wbData : em.storeData;
    assign memAddr   = em.aluResult;

    always_comb begin
        if (!em.store) begin
            memByteEn = 4'b0000;
        end else if (em.memOp == MEM_WORD) begin
            memByteEn = 4'b1111;
        end else begin
            memByteEn = 4'b0001 << em.aluResult[1:0];  // byte lane from address
        end
    end

    // byte copied to every lane, strobe picks the one written
    assign memWriteData = (em.memOp == MEM_WORD) ? storeData : {4{storeData[7:0]}};

    assign loadByte = memReadData[8 * em.aluResult[1:0] +: 8];

    always_comb begin
        case (em.memOp)
            MEM_BYTE_S: loadData = {{24{loadByte[7]}}, loadByte};
            MEM_BYTE_U: loadData = {24'd0, loadByte};
            default:    loadData = memReadData;
        endcase
    end

    // only valid for forwarding once tnew reaches zero
    assign memResult = em.aluResult;

    always_comb begin
        mw.pc       = em.pc;
        mw.result   = (em.resultSrc == RES_MEM) ? loadData : em.aluResult;
        mw.dest     = em.dest;
        mw.regWrite = em.regWrite;
    end

endmodule

/* hdl/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop #(
    parameter cpuPkg::wordT resetPc = cpuPkg::resetPc
) (
    input  logic           clk,
    input  logic           rstN,
    output cpuPkg::wordT   imAddr,
    input  cpuPkg::wordT   imData,
    output cpuPkg::wordT   memAddr,
    input  cpuPkg::wordT   memReadData,
    output cpuPkg::wordT   memWriteData,
    output logic [3:0]     memByteEn,
    output logic           grfWriteEnable,
    output cpuPkg::regNumT grfWriteNumber,
    output cpuPkg::wordT   grfWriteData,
    output cpuPkg::wordT   grfPc
);
    import cpuPkg::*;

    wordT      fetchPc, target, memResult;
    logic      stall, redirect, useRsD, useRtD;
    regNumT    rsNum, rtNum;
    fwdSelT    fwdRsD, fwdRtD, fwdRsE, fwdRtE, fwdRtM;
    fdPayloadT fdIn, fdOut;
    dePayloadT deIn, deOut;
    emPayloadT emIn, emOut;
    mwPayloadT mwIn, mwOut;

    assign imAddr = fetchPc;
    assign fdIn   = '{pc: fetchPc, instr: imData};

    fetchStage #(.resetPc(resetPc)) fetch_i (
        .clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect), .target(target), .pc(fetchPc)
    );

    pipeReg #(.payloadT(fdPayloadT)) fdReg_i (
        .clk(clk), .rstN(rstN), .hold(stall), .bubble(1'b0), .d(fdIn), .q(fdOut)
    );

    decodeStage decode_i (
        .clk(clk), .rstN(rstN), .fd(fdOut),
        .wbNum(mwOut.dest), .wbWrite(mwOut.regWrite), .wbData(mwOut.result),
        .memResult(memResult), .fwdRs(fwdRsD), .fwdRt(fwdRtD),
        .rsNum(rsNum), .rtNum(rtNum), .useRsD(useRsD), .useRtD(useRtD),
        .redirect(redirect), .target(target), .de(deIn)
    );

    hazardUnit hazard_i (
        .rsNum(rsNum), .rtNum(rtNum), .useRsD(useRsD), .useRtD(useRtD),
        .de(deOut), .em(emOut), .wbNum(mwOut.dest), .wbWrite(mwOut.regWrite),
        .stall(stall), .fwdRsD(fwdRsD), .fwdRtD(fwdRtD),
        .fwdRsE(fwdRsE), .fwdRtE(fwdRtE), .fwdRtM(fwdRtM)
    );

    // a stall leaves decode in place and sends a bubble down
    pipeReg #(.payloadT(dePayloadT)) deReg_i (
        .clk(clk), .rstN(rstN), .hold(1'b0), .bubble(stall), .d(deIn), .q(deOut)
    );

    executeStage execute_i (
        .de(deOut), .memResult(memResult), .wbData(mwOut.result),
        .fwdRs(fwdRsE), .fwdRt(fwdRtE), .em(emIn)
    );

    pipeReg #(.payloadT(emPayloadT)) emReg_i (
        .clk(clk), .rstN(rstN), .hold(1'b0), .bubble(1'b0), .d(emIn), .q(emOut)
    );

    memoryStage memory_i (
        .em(emOut), .memReadData(memReadData), .wbData(mwOut.result), .fwdRt(fwdRtM),
        .memAddr(memAddr), .memWriteData(memWriteData), .memByteEn(memByteEn),
        .memResult(memResult), .mw(mwIn)
    );

    pipeReg #(.payloadT(mwPayloadT)) mwReg_i (
        .clk(clk), .rstN(rstN), .hold(1'b0), .bubble(1'b0), .d(mwIn), .q(mwOut)
    );

    assign grfWriteEnable = mwOut.regWrite;  // retire trace
    assign grfWriteNumber = mwOut.dest;
    assign grfWriteData   = mwOut.result;
    assign grfPc          = mwOut.pc;

endmodule

/* dv/cpuTop_properties.sv */
`timescale 1ns/10ps

module cpuTop_properties (
    input logic        clk,
    input logic        rstN,
    input logic        stall,
    input logic [31:0] imAddr,
    input logic [3:0]  memByteEn,
    input logic        grfWriteEnable,
    input logic [4:0]  grfWriteNumber
);

    int assertFails = 0;

    strobeShape: assert property (@(posedge clk) disable iff (!rstN)
        memByteEn inside {4'b0000, 4'b1111, 4'b0001, 4'b0010, 4'b0100, 4'b1000})
        else begin
            $error("memByteEn has an illegal pattern");
            assertFails++;
        end

    // outputs are cleared by the reset edge
    quietInReset: assert property (@(posedge clk)
        !rstN |=> (!grfWriteEnable && memByteEn == 4'b0000))
        else begin
            $error("strobe active during reset");
            assertFails++;
        end

    noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
        grfWriteEnable |-> grfWriteNumber != 5'd0)
        else begin
            $error("write to register 0");
            assertFails++;
        end

    pcHolds: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> imAddr == $past(imAddr))
        else begin
            $error("fetch address moved during stall");
            assertFails++;
        end

endmodule

/* dv/retireChecker.sv */
`timescale 1ns/10ps

module retireChecker #(
    parameter int numEntries = 1
) (
    input  logic         clk,
    input  logic         rstN,
    input  logic         grfWriteEnable,
    input  logic [4:0]   grfWriteNumber,
    input  logic [31:0]  grfWriteData,
    input  logic [31:0]  grfPc,
    input  logic [31:0]  memAddr,
    input  logic [31:0]  memWriteData,
    input  logic [3:0]   memByteEn,
    input  logic         expStore [numEntries],
    input  int           expTest [numEntries],
    input  logic [31:0]  expA [numEntries],
    input  logic [31:0]  expB [numEntries],
    input  logic [31:0]  expC [numEntries],
    output int           entriesDone,
    output int           errors,
    output int           testsPassed,
    output int           testsFailed
);

    int testErrors;

    initial begin
        entriesDone = 0;
        errors      = 0;
        testsPassed = 0;
        testsFailed = 0;
        testErrors  = 0;
    end

    task automatic compare(string name, logic [31:0] expVal, logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expVal, actVal);
            errors++;
            testErrors++;
        end
    endtask

    // closes the test once its last row is done
    task automatic advance();
        int i;
        i = entriesDone;
        entriesDone++;
        if (entriesDone == numEntries || expTest[entriesDone] != expTest[i]) begin
            $display("test %0d finished with %0d errors", expTest[i], testErrors);
            if (testErrors == 0) testsPassed++;
            else testsFailed++;
            testErrors = 0;
        end
    endtask

    always @(negedge clk) begin
        if (rstN && grfWriteEnable) begin  // older than a store in the same cycle
            if (entriesDone >= numEntries || expStore[entriesDone]) begin
                $display("unexpected register write to r%0d from pc %h", grfWriteNumber, grfPc);
                errors++;
            end else begin
                compare("grfPc", expA[entriesDone], grfPc);
                compare("grfWriteNumber", expB[entriesDone], 32'(grfWriteNumber));
                compare("grfWriteData", expC[entriesDone], grfWriteData);
                advance();
            end
        end
        if (rstN && memByteEn != 4'b0000) begin
            if (entriesDone >= numEntries || !expStore[entriesDone]) begin
                $display("unexpected store to address %h", memAddr);
                errors++;
            end else begin
                compare("memAddr", expA[entriesDone], memAddr);
                compare("memByteEn", expB[entriesDone], 32'(memByteEn));
                compare("memWriteData", expC[entriesDone], memWriteData);
                advance();
            end
        end
    end

endmodule

/* dv/tbTop.sv */
`timescale 1ns/10ps

module tbTop;
    import cpuPkg::*;

    localparam int progLen    = 35;
    localparam int numEntries = 26;
    localparam int cycleLimit = 8 * progLen + 20;

    logic       clk;
    logic       rstN;
    wordT       imAddr, imData, memAddr, memReadData, memWriteData, grfWriteData, grfPc;
    logic [3:0] memByteEn;
    logic       grfWriteEnable;
    regNumT     grfWriteNumber;

    wordT        prog [progLen];
    logic [7:0]  dataMem [0:1023];
    logic        expStore [numEntries];
    int          expTest [numEntries];
    logic [31:0] expA [numEntries];
    logic [31:0] expB [numEntries];
    logic [31:0] expC [numEntries];
    int          entriesDone, errors, testsPassed, testsFailed, cycles;
    wordT        memWord;

    function automatic wordT rType(int rs, int rt, int rd, functT f);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
    endfunction

    function automatic wordT iType(opcodeT op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // kind, test, pc or address, register or strobe, value or data
    task automatic addEntry(int i, logic st, int t, wordT a, wordT b, wordT c);
        expStore[i] = st;
        expTest[i]  = t;
        expA[i]     = a;
        expB[i]     = b;
        expC[i]     = c;
    endtask

    always #20 clk = ~clk;

    cpuTop #(.resetPc(32'h0000_3000)) dut_i (.*);

    retireChecker #(.numEntries(numEntries)) checker_i (
        .clk(clk), .rstN(rstN), .grfWriteEnable(grfWriteEnable),
        .grfWriteNumber(grfWriteNumber), .grfWriteData(grfWriteData), .grfPc(grfPc),
        .memAddr(memAddr), .memWriteData(memWriteData), .memByteEn(memByteEn),
        .expStore(expStore), .expTest(expTest), .expA(expA), .expB(expB), .expC(expC),
        .entriesDone(entriesDone), .errors(errors),
        .testsPassed(testsPassed), .testsFailed(testsFailed)
    );

    bind cpuTop cpuTop_properties props_i (
        .clk(clk), .rstN(rstN), .stall(stall), .imAddr(imAddr), .memByteEn(memByteEn),
        .grfWriteEnable(grfWriteEnable), .grfWriteNumber(grfWriteNumber)
    );

    // instruction memory indexed from 0x3000, zeros (nop) outside the program
    assign imData = (imAddr >= 32'h3000 && imAddr < 32'h3000 + 4 * progLen) ?
                    prog[(imAddr - 32'h3000) >> 2] : 32'h0;
    assign memWord     = {memAddr[31:2], 2'b00};
    assign memReadData = {dataMem[memWord[9:0] + 3], dataMem[memWord[9:0] + 2],
                          dataMem[memWord[9:0] + 1], dataMem[memWord[9:0]]};

    always @(negedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (memByteEn[b]) begin
                dataMem[memWord[9:0] + b] <= memWriteData[8 * b +: 8];
            end
        end
    end

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        for (int i = 0; i < 1024; i++) dataMem[i] = 8'h00;
        prog = '{
            iType(OP_ORI, 0, 1, 16'h1234), iType(OP_LUI, 0, 2, 16'h8765),
            rType(1, 2, 3, F_ADDU), rType(3, 1, 4, F_SUBU),
            rType(3, 1, 5, F_AND), rType(4, 5, 6, F_OR),
            rType(2, 1, 7, F_SLT), rType(1, 2, 8, F_SLT),
            iType(OP_ORI, 0, 9, 16'h0100), iType(OP_SW, 9, 3, 16'h0000),
            iType(OP_ORI, 0, 10, 16'h0080), iType(OP_SB, 9, 10, 16'h0005),
            iType(OP_LB, 9, 11, 16'h0005), iType(OP_LBU, 9, 12, 16'h0005),
            iType(OP_LW, 9, 13, 16'h0000), rType(13, 1, 14, F_ADDU),
            iType(OP_LW, 9, 15, 16'h0004), iType(OP_BEQ, 15, 0, 16'h0002),
            iType(OP_ORI, 0, 16, 16'h0011), iType(OP_BEQ, 1, 1, 16'h0002),
            iType(OP_ORI, 0, 17, 16'h0022), iType(OP_ORI, 0, 18, 16'h0bad),
            iType(OP_BNE, 17, 16, 16'h0002), iType(OP_ORI, 0, 19, 16'h0033),
            iType(OP_ORI, 0, 20, 16'h0bad), iType(OP_BNE, 19, 19, 16'h0002),
            iType(OP_ORI, 0, 21, 16'h0044), {OP_JAL, 26'h0000c20},
            iType(OP_ORI, 0, 22, 16'h0055), iType(OP_ORI, 0, 23, 16'h0066),
            iType(OP_BEQ, 0, 0, 16'hffff), 32'h0,
            iType(OP_ORI, 0, 24, 16'h0077), rType(31, 0, 0, F_JR),
            iType(OP_ORI, 0, 25, 16'h0088)
        };
        addEntry(0, 0, 1, 32'h3000, 1, 32'h0000_1234);
        addEntry(1, 0, 1, 32'h3004, 2, 32'h8765_0000);
        addEntry(2, 0, 2, 32'h3008, 3, 32'h8765_1234);
        addEntry(3, 0, 2, 32'h300c, 4, 32'h8765_0000);
        addEntry(4, 0, 2, 32'h3010, 5, 32'h0000_1234);
        addEntry(5, 0, 2, 32'h3014, 6, 32'h8765_1234);
        addEntry(6, 0, 2, 32'h3018, 7, 32'h0000_0001);
        addEntry(7, 0, 2, 32'h301c, 8, 32'h0000_0000);
        addEntry(8, 0, 3, 32'h3020, 9, 32'h0000_0100);
        addEntry(9, 1, 3, 32'h0100, 4'b1111, 32'h8765_1234);
        addEntry(10, 0, 3, 32'h3028, 10, 32'h0000_0080);
        addEntry(11, 1, 3, 32'h0105, 4'b0010, 32'h8080_8080);
        addEntry(12, 0, 3, 32'h3030, 11, 32'hffff_ff80);
        addEntry(13, 0, 3, 32'h3034, 12, 32'h0000_0080);
        addEntry(14, 0, 3, 32'h3038, 13, 32'h8765_1234);
        addEntry(15, 0, 4, 32'h303c, 14, 32'h8765_2468);
        addEntry(16, 0, 4, 32'h3040, 15, 32'h0000_8000);
        addEntry(17, 0, 4, 32'h3048, 16, 32'h0000_0011);
        addEntry(18, 0, 5, 32'h3050, 17, 32'h0000_0022);
        addEntry(19, 0, 5, 32'h305c, 19, 32'h0000_0033);
        addEntry(20, 0, 5, 32'h3068, 21, 32'h0000_0044);
        addEntry(21, 0, 6, 32'h306c, 31, 32'h0000_3074);
        addEntry(22, 0, 6, 32'h3070, 22, 32'h0000_0055);
        addEntry(23, 0, 6, 32'h3080, 24, 32'h0000_0077);
        addEntry(24, 0, 6, 32'h3088, 25, 32'h0000_0088);
        addEntry(25, 0, 6, 32'h3074, 23, 32'h0000_0066);
        cycles = 0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        while (entriesDone < numEntries && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, only %0d of %0d expected events seen",
                     cycles, entriesDone, numEntries);
            $display("*** FAILED ***");
        end else begin
            repeat (20) @(negedge clk);  // catch stray writes
            $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                     testsPassed, testsFailed, errors, dut_i.props_i.assertFails);
            if (errors == 0 && testsFailed == 0 && dut_i.props_i.assertFails == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
        end
        $finish;
    end

endmodule

/* filelist.f */
common/cpuPkg.sv
hdl/pipeReg.sv
hdl/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
dv/cpuTop_properties.sv
dv/retireChecker.sv
dv/tbTop.sv
